// File: rtl/chan_readout_pkg.sv
package chan_readout_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths of the memory side and the link side
  localparam int BURST_W         = 128;  // one DDR3 read burst
  localparam int WORD_W          = 32;   // one word on the link to the master
  localparam int WORDS_PER_BURST = 4;    // link words cut from each burst

  // lane index width inside the width converter
  localparam int LANE_W          = $clog2(WORDS_PER_BURST);

  ////////////////////////////////////////////////////////////////////////////
  // buffering and master reset handling
  localparam int FIFO_DEPTH        = 4;   // default entries per stream FIFO
  localparam int LONG_RESET_CYCLES = 16;  // synced high cycles that make a full reset

  // high-time counter holds 0 .. LONG_RESET_CYCLES
  localparam int RST_CNT_W         = $clog2(LONG_RESET_CYCLES + 1);

  // completed fill counter, cleared by a short master pulse
  localparam int FILL_COUNT_W      = 24;

  ////////////////////////////////////////////////////////////////////////////
  // stream beats

  // burst as read back from memory, last marks the end of a fill
  typedef struct packed {
    logic [BURST_W-1:0] data;  // four link words, lowest word in the low bits
    logic               last;  // final burst of the fill
  } burst_beat_t;

  // single word toward the link
  typedef struct packed {
    logic [WORD_W-1:0] data;   // payload word
    logic              last;   // final word of a packet
  } word_beat_t;

  // 129 and 33 bits wide in total
  // fill path and command path both end in word_beat_t
  // so the arbiter can mux them without any repacking

endpackage

// File: rtl/master_reset_filter.sv
`timescale 1ns/1ps

module master_reset_filter (
  input  logic clk125,
  input  logic rst,
  input  logic rst_from_master,  // raw line from the master, async to clk125
  output logic evt_cnt_reset,    // one-cycle strobe after a short pulse
  output logic path_rst          // held high during a long pulse
);
  import chan_readout_pkg::*;

  logic                 sync_meta;  // first synchronizer stage
  logic                 sync_q;     // synchronized master line
  logic [RST_CNT_W-1:0] high_cnt;   // consecutive high cycles, saturating
  logic                 long_held;  // pulse has been long enough for a full reset
  logic                 short_end;  // line fell after a short high time

  // two flop synchronizer
  always_ff @(posedge clk125) begin
    if (rst) begin
      sync_meta <= 1'b0;
      sync_q    <= 1'b0;
    end else begin
      sync_meta <= rst_from_master;
      sync_q    <= sync_meta;
    end
  end

  // falling edge seen while the count never reached the long threshold
  assign short_end = !sync_q && (high_cnt != '0)
                     && (high_cnt < RST_CNT_W'(LONG_RESET_CYCLES));

  always_ff @(posedge clk125) begin
    if (rst) begin
      high_cnt      <= '0;
      long_held     <= 1'b0;
      evt_cnt_reset <= 1'b0;
    end else begin
      evt_cnt_reset <= short_end;  // strobe lands one cycle after the fall
      if (sync_q) begin
        if (high_cnt != RST_CNT_W'(LONG_RESET_CYCLES))
          high_cnt <= high_cnt + 1'b1;  // saturate at the threshold
      end else begin
        high_cnt <= '0;
      end
      // set on the LONG_RESET_CYCLES-th high cycle, clear once the line is low
      long_held <= sync_q && (long_held
                              || (high_cnt == RST_CNT_W'(LONG_RESET_CYCLES - 1)));
    end
  end

  assign path_rst = rst || long_held;  // local reset also flushes the path

  // a pulse is either short or long, never both
  a_short_long_excl: assert property (@(posedge clk125)
    !(evt_cnt_reset && path_rst));

endmodule

// File: rtl/axis_stream_fifo.sv
`timescale 1ns/1ps

module axis_stream_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = chan_readout_pkg::FIFO_DEPTH
) (
  input  logic     clk125,
  input  logic     rst,
  input  payload_t in_beat,
  input  logic     in_valid,
  output logic     in_ready,   // low only when full
  output payload_t out_beat,   // head of the queue, shown ahead
  output logic     out_valid,
  input  logic     out_ready
);

  typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
  typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

  payload_t mem [DEPTH];  // payload storage
  ptr_t     wr_ptr;
  ptr_t     rd_ptr;
  cnt_t     count;        // entries held
  logic     push;
  logic     pop;

  assign in_ready  = (count != cnt_t'(DEPTH));
  assign out_valid = (count != '0);
  assign out_beat  = mem[rd_ptr];  // show-ahead read

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  // storage write, no reset on payload
  always_ff @(posedge clk125) begin
    if (push)
      mem[wr_ptr] <= in_beat;
  end

  ////////////////////////////////////////////////////////////////////////////
  // pointers and occupancy
  always_ff @(posedge clk125) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push)
        wr_ptr <= (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // wrap
      if (pop)
        rd_ptr <= (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // idle or simultaneous push and pop
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  a_count_bound: assert property (@(posedge clk125) disable iff (rst)
    count <= cnt_t'(DEPTH));

  // head must not move or change while the consumer stalls
  a_head_hold: assert property (@(posedge clk125) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_beat));

endmodule

// File: rtl/burst_width_converter.sv
`timescale 1ns/1ps

module burst_width_converter (
  input  logic                           clk125,
  input  logic                           rst,
  input  chan_readout_pkg::burst_beat_t  burst,        // head of the fill FIFO
  input  logic                           burst_valid,
  output logic                           burst_ready,  // pops the burst on word 3
  output chan_readout_pkg::word_beat_t   word,
  output logic                           word_valid,
  input  logic                           word_ready
);
  import chan_readout_pkg::*;

  logic [LANE_W-1:0] lane;       // current 32-bit slice, lowest first
  logic              armed;      // burst has been presented for a cycle
  logic              last_lane;  // on the final slice of the burst
  logic              word_xfer;

  assign last_lane = (lane == LANE_W'(WORDS_PER_BURST - 1));

  // word 0 goes valid one cycle after the burst shows up
  assign word_valid = burst_valid && armed;
  assign word_xfer  = word_valid && word_ready;

  // slice straight from the FIFO head, the FIFO holds it steady
  assign word.data = burst.data[lane*WORD_W +: WORD_W];
  assign word.last = burst.last && last_lane;  // only on the burst's final word

  assign burst_ready = word_xfer && last_lane;  // take the burst with word 3

  always_ff @(posedge clk125) begin
    if (rst) begin
      lane  <= '0;
      armed <= 1'b0;
    end else begin
      armed <= burst_valid && !burst_ready;  // drops for a cycle after each pop
      if (word_xfer)
        lane <= last_lane ? '0 : lane + 1'b1;  // wrap after word 3
    end
  end

  // stalled word stays put across the FIFO and the converter
  a_word_hold: assert property (@(posedge clk125) disable iff (rst)
    word_valid && !word_ready |=> word_valid && $stable(word));

endmodule

// File: rtl/link_tx_arbiter.sv
`timescale 1ns/1ps

module link_tx_arbiter (
  input  logic                                     clk125,
  input  logic                                     rst,
  input  logic                                     evt_cnt_reset,  // short master pulse
  input  logic                                     link_pause,     // async from the master
  input  chan_readout_pkg::word_beat_t             fill_word,
  input  logic                                     fill_valid,
  output logic                                     fill_ready,
  input  chan_readout_pkg::word_beat_t             cmd_word,
  input  logic                                     cmd_valid,
  output logic                                     cmd_ready,
  output chan_readout_pkg::word_beat_t             link_tx,
  output logic                                     link_valid,
  input  logic                                     link_ready,
  output logic [chan_readout_pkg::FILL_COUNT_W-1:0] fill_count
);

  logic pause_meta;   // pause synchronizer stage 1
  logic pause_sync;   // pause synchronizer stage 2
  logic pkt_open;     // packet in progress or beat on offer
  logic grant_fill;   // locked source, 1 selects fill
  logic sel_fill;     // source used this cycle
  logic src_valid;
  logic link_xfer;

  ////////////////////////////////////////////////////////////////////////////
  // pause synchronizer
  always_ff @(posedge clk125) begin
    if (rst) begin
      pause_meta <= 1'b0;
      pause_sync <= 1'b0;
    end else begin
      pause_meta <= link_pause;
      pause_sync <= pause_meta;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // source select
  // idle link takes a new grant, fill wins a tie
  always_comb begin
    if (pkt_open)
      sel_fill = grant_fill;
    else if (fill_valid)
      sel_fill = 1'b1;
    else if (cmd_valid)
      sel_fill = 1'b0;
    else
      sel_fill = grant_fill;  // nothing waiting, keep the old one
  end

  assign src_valid  = sel_fill ? fill_valid : cmd_valid;
  assign link_valid = src_valid && !pause_sync;       // pause hides the link
  assign link_tx    = sel_fill ? fill_word : cmd_word;
  assign link_xfer  = link_valid && link_ready;

  // ready only to the granted source, and only while its beat goes through
  assign fill_ready = sel_fill && link_xfer;
  assign cmd_ready  = !sel_fill && link_xfer;

  // once a beat is offered the grant is held until last goes through
  always_ff @(posedge clk125) begin
    if (rst) begin
      pkt_open   <= 1'b0;
      grant_fill <= 1'b0;
    end else if (link_valid) begin
      grant_fill <= sel_fill;
      pkt_open   <= !(link_ready && link_tx.last);  // close on the last beat
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // completed fills
  always_ff @(posedge clk125) begin
    if (rst || evt_cnt_reset)
      fill_count <= '0;
    else if (link_xfer && sel_fill && link_tx.last)
      fill_count <= fill_count + 1'b1;
  end

  a_one_ready: assert property (@(posedge clk125) disable iff (rst)
    !(fill_ready && cmd_ready));

endmodule

// File: rtl/chan_readout_top.sv
`timescale 1ns/1ps

module chan_readout_top (
  input  logic                                     clk125,
  input  logic                                     rst,
  input  logic                                     rst_from_master,  // master reset line
  input  logic                                     link_pause,       // readout pause line
  input  chan_readout_pkg::burst_beat_t            fill_in,          // bursts from memory
  input  logic                                     fill_in_valid,
  output logic                                     fill_in_ready,
  input  chan_readout_pkg::word_beat_t             cmd_in,           // command processor words
  input  logic                                     cmd_in_valid,
  output logic                                     cmd_in_ready,
  output chan_readout_pkg::word_beat_t             link_tx,          // toward the serial link
  output logic                                     link_valid,
  input  logic                                     link_ready,
  output logic [chan_readout_pkg::FILL_COUNT_W-1:0] fill_count
);
  import chan_readout_pkg::*;

  logic        evt_cnt_reset;  // short pulse strobe
  logic        path_rst;       // local or long master reset

  burst_beat_t fifo_burst;     // fill FIFO head
  logic        fifo_burst_valid;
  logic        fifo_burst_ready;

  word_beat_t  fill_word;      // converter output
  logic        fill_word_valid;
  logic        fill_word_ready;

  word_beat_t  cmd_word;       // command FIFO head
  logic        cmd_word_valid;
  logic        cmd_word_ready;

  ////////////////////////////////////////////////////////////////////////////
  // master reset handling
  master_reset_filter u_reset_filter (
    .clk125          (clk125),
    .rst             (rst),
    .rst_from_master (rst_from_master),
    .evt_cnt_reset   (evt_cnt_reset),
    .path_rst        (path_rst)
  );

  ////////////////////////////////////////////////////////////////////////////
  // fill path
  axis_stream_fifo #(.payload_t(burst_beat_t)) u_fill_fifo (
    .clk125    (clk125),
    .rst       (path_rst),
    .in_beat   (fill_in),
    .in_valid  (fill_in_valid),
    .in_ready  (fill_in_ready),
    .out_beat  (fifo_burst),
    .out_valid (fifo_burst_valid),
    .out_ready (fifo_burst_ready)
  );

  burst_width_converter u_width_conv (
    .clk125      (clk125),
    .rst         (path_rst),
    .burst       (fifo_burst),
    .burst_valid (fifo_burst_valid),
    .burst_ready (fifo_burst_ready),
    .word        (fill_word),
    .word_valid  (fill_word_valid),
    .word_ready  (fill_word_ready)
  );

  // command path
  axis_stream_fifo #(.payload_t(word_beat_t)) u_cmd_fifo (
    .clk125    (clk125),
    .rst       (path_rst),
    .in_beat   (cmd_in),
    .in_valid  (cmd_in_valid),
    .in_ready  (cmd_in_ready),
    .out_beat  (cmd_word),
    .out_valid (cmd_word_valid),
    .out_ready (cmd_word_ready)
  );

  ////////////////////////////////////////////////////////////////////////////
  // merge onto the link
  link_tx_arbiter u_tx_arb (
    .clk125        (clk125),
    .rst           (path_rst),
    .evt_cnt_reset (evt_cnt_reset),
    .link_pause    (link_pause),
    .fill_word     (fill_word),
    .fill_valid    (fill_word_valid),
    .fill_ready    (fill_word_ready),
    .cmd_word      (cmd_word),
    .cmd_valid     (cmd_word_valid),
    .cmd_ready     (cmd_word_ready),
    .link_tx       (link_tx),
    .link_valid    (link_valid),
    .link_ready    (link_ready),
    .fill_count    (fill_count)
  );

endmodule

// File: dv/chan_readout_tb.sv
`timescale 1ns/1ps

module chan_readout_tb;
  import chan_readout_pkg::*;

  localparam int SRC_NONE   = 0;     // comparator between packets
  localparam int SRC_FILL   = 1;
  localparam int SRC_CMD    = 2;
  localparam int READY_ON   = 0;     // link_ready modes
  localparam int READY_RAND = 1;
  localparam int READY_OFF  = 2;
  localparam int WAIT_LIMIT = 2000;  // cycles allowed per wait loop

  logic                    clk125;
  logic                    rst;
  logic                    rst_from_master;
  logic                    link_pause;
  burst_beat_t             fill_in;
  logic                    fill_in_valid;
  logic                    fill_in_ready;
  word_beat_t              cmd_in;
  logic                    cmd_in_valid;
  logic                    cmd_in_ready;
  word_beat_t              link_tx;
  logic                    link_valid;
  logic                    link_ready;
  logic [FILL_COUNT_W-1:0] fill_count;

  word_beat_t exp_fill[$];             // expected fill words, oldest first
  word_beat_t exp_cmd[$];              // expected command words
  int         cur_src    = SRC_NONE;   // source of the open link packet
  int         fills_seen = 0;          // fill packets completed on the link
  int         fills_base = 0;          // fills_seen at the last counter clear
  int         ready_mode = READY_ON;

  chan_readout_top u_dut (.*);

  initial begin
    clk125 = 1'b0;
    forever #5 clk125 = ~clk125;  // 100 MHz stand-in for the 125 MHz clock
  end

  task automatic abort_run(input string why);
    $display("Test failures found");
    $fatal(1, "%s", why);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference model and stimulus

  // expected words of one burst, lowest slice first, last only on the final slice
  function automatic void expand_burst(input burst_beat_t b);
    logic [BURST_W-1:0] rest;
    word_beat_t         w;
    rest = b.data;
    for (int k = 0; k < WORDS_PER_BURST; k++) begin
      w.data = rest[WORD_W-1:0];
      w.last = b.last && (k == WORDS_PER_BURST - 1);
      exp_fill.push_back(w);
      rest = rest >> WORD_W;  // next slice down into the low bits
    end
  endfunction

  function automatic burst_beat_t random_burst(input logic last);
    burst_beat_t b;
    for (int i = 0; i < WORDS_PER_BURST; i++)
      b.data[i*WORD_W +: WORD_W] = $urandom & 32'h7fff_ffff;  // fill words keep bit 31 low
    b.last = last;
    return b;
  endfunction

  task automatic push_burst(input burst_beat_t b);
    int waited = 0;
    fill_in       = b;
    fill_in_valid = 1'b1;
    while (!fill_in_ready) begin  // FIFO full, hold the beat
      @(negedge clk125);
      waited++;
      if (waited > WAIT_LIMIT)
        abort_run("fill input stayed not ready past the timeout");
    end
    @(negedge clk125);            // taken on the edge just passed
    fill_in_valid = 1'b0;
  endtask

  task automatic push_cmd(input word_beat_t w);
    int waited = 0;
    cmd_in       = w;
    cmd_in_valid = 1'b1;
    while (!cmd_in_ready) begin
      @(negedge clk125);
      waited++;
      if (waited > WAIT_LIMIT)
        abort_run("command input stayed not ready past the timeout");
    end
    @(negedge clk125);
    cmd_in_valid = 1'b0;
  endtask

  task automatic send_fill_packet(input int nb);
    burst_beat_t b;
    for (int i = 0; i < nb; i++) begin
      b = random_burst(i == nb - 1);
      expand_burst(b);
      push_burst(b);
      repeat ($urandom % 3) @(negedge clk125);  // random idle gap
    end
  endtask

  task automatic send_cmd_packet(input int nw);
    word_beat_t w;
    for (int i = 0; i < nw; i++) begin
      w.data = $urandom | 32'h8000_0000;  // bit 31 marks a command word
      w.last = (i == nw - 1);
      exp_cmd.push_back(w);
      push_cmd(w);
      repeat ($urandom % 3) @(negedge clk125);
    end
  endtask

  // both sources run at once so the arbiter sees contention
  task automatic run_traffic(input int n_fill, input int n_cmd);
    fork
      begin
        for (int i = 0; i < n_fill; i++) send_fill_packet(1 + $urandom % 3);
      end
      begin
        for (int i = 0; i < n_cmd; i++) send_cmd_packet(1 + $urandom % 4);
      end
    join
  endtask

  task automatic pulse_master_reset(input int cycles);
    rst_from_master = 1'b1;
    repeat (cycles) @(negedge clk125);
    rst_from_master = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // checks and waits

  task automatic wait_drain();
    int waited = 0;
    while (exp_fill.size() != 0 || exp_cmd.size() != 0 || cur_src != SRC_NONE) begin
      @(negedge clk125);
      waited++;
      if (waited > WAIT_LIMIT)
        abort_run("expected link words still outstanding after the drain timeout");
    end
  endtask

  task automatic wait_count_cleared();
    int waited = 0;
    while (fill_count != '0) begin  // short master pulse clears the counter
      @(negedge clk125);
      waited++;
      if (waited > WAIT_LIMIT)
        abort_run("fill counter was not cleared by the short master reset pulse");
    end
  endtask

  task automatic check_fill_count();
    logic [FILL_COUNT_W-1:0] exp_cnt;
    exp_cnt = FILL_COUNT_W'(fills_seen - fills_base);
    assert (fill_count == exp_cnt) else begin
      $display("ERROR %0t: fill_count expected %0d actual %0d", $time, exp_cnt, fill_count);
      abort_run("fill counter mismatch");
    end
  endtask

  task automatic expect_link_idle(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge clk125);
      assert (!link_valid) else begin
        $display("ERROR %0t: link_valid expected 0 actual %b", $time, link_valid);
        abort_run("link active while paused or flushed");
      end
    end
  endtask

  // link back-pressure, changed on the falling edge only
  initial begin : drive_link_ready
    link_ready = 1'b0;
    forever begin
      @(negedge clk125);
      case (ready_mode)
        READY_ON:   link_ready = 1'b1;
        READY_RAND: link_ready = ($urandom % 4) != 0;  // about 3 of 4 cycles ready
        default:    link_ready = 1'b0;
      endcase
    end
  end

  // first word of a packet picks the queue, the rest must follow in order
  initial begin : compare_link
    word_beat_t exp_w;
    forever begin
      @(posedge clk125);
      if (link_valid && link_ready) begin
        if (cur_src == SRC_NONE)
          cur_src = link_tx.data[WORD_W-1] ? SRC_CMD : SRC_FILL;
        if (cur_src == SRC_FILL) begin
          assert (exp_fill.size() != 0)
            else abort_run("fill word on the link that was never sent");
          exp_w = exp_fill.pop_front();
        end else begin
          assert (exp_cmd.size() != 0)
            else abort_run("command word on the link that was never sent");
          exp_w = exp_cmd.pop_front();
        end
        assert (link_tx == exp_w) else begin
          $display("ERROR %0t: link_tx expected %h actual %h", $time, exp_w, link_tx);
          abort_run("link word mismatch");
        end
        if (link_tx.last) begin
          if (cur_src == SRC_FILL)
            fills_seen++;
          cur_src = SRC_NONE;  // packet closed
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  initial begin : main_seq
    int waited;
    void'($urandom(32'h329f));
    rst             = 1'b1;
    rst_from_master = 1'b0;
    link_pause      = 1'b0;
    fill_in         = '0;
    fill_in_valid   = 1'b0;
    cmd_in          = '0;
    cmd_in_valid    = 1'b0;
    repeat (2) @(posedge clk125);
    @(negedge clk125);
    rst = 1'b0;
    expect_link_idle(1);  // quiet out of reset
    check_fill_count();

    // fill and command packets, link always ready
    run_traffic(6, 6);
    wait_drain();
    check_fill_count();

    // pause holds the link, traffic queues up behind it
    link_pause = 1'b1;
    repeat (2) @(negedge clk125);  // two synchronizer flops
    fork
      expect_link_idle(40);
      send_fill_packet(2);
      send_cmd_packet(3);
    join
    link_pause = 1'b0;
    wait_drain();
    check_fill_count();

    // random back-pressure
    ready_mode = READY_RAND;
    run_traffic(10, 10);
    wait_drain();
    check_fill_count();

    // short master pulse while command words are in flight
    fork
      begin
        send_cmd_packet(4);
        send_cmd_packet(3);
      end
      begin
        repeat (3) @(negedge clk125);
        pulse_master_reset(4);
      end
    join
    wait_count_cleared();
    fills_base = fills_seen;
    run_traffic(4, 4);
    wait_drain();
    check_fill_count();

    // long master pulse flushes words stalled in the path
    ready_mode = READY_OFF;
    repeat (2) @(negedge clk125);
    fork
      send_fill_packet(2);
      send_cmd_packet(3);
    join
    waited = 0;
    while (!link_valid) begin
      @(negedge clk125);
      waited++;
      if (waited > WAIT_LIMIT)
        abort_run("no word reached the stalled link before the flush");
    end
    fork
      pulse_master_reset(24);
      begin
        repeat (19) @(negedge clk125);  // path reset is in effect by now
        expect_link_idle(5);
      end
    join
    expect_link_idle(6);   // until path_rst has fallen
    exp_fill.delete();     // flushed words never reach the link
    exp_cmd.delete();
    fills_base = fills_seen;
    check_fill_count();
    ready_mode = READY_RAND;
    run_traffic(6, 6);
    wait_drain();
    check_fill_count();

    $display("All tests passed!");
    $finish;
  end

endmodule

// File: flist.f
rtl/chan_readout_pkg.sv
rtl/master_reset_filter.sv
rtl/axis_stream_fifo.sv
rtl/burst_width_converter.sv
rtl/link_tx_arbiter.sv
rtl/chan_readout_top.sv
dv/chan_readout_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the readout testbench, exit status is the simulation result
cd "$(dirname "$0")" \
  && verilator --binary --assert -Wno-fatal --top-module chan_readout_tb \
       -f flist.f -o chan_readout_sim \
  && ./obj_dir/chan_readout_sim \
  || { echo "simulation build or run failed" >&2; exit 1; }
